// File: tests/game_golden.txt
# Records: W cycles | C addr data | P paddle_y | E ball_x ball_y moving_left game_over
# All values decimal, each record takes one cycle except W which takes its count.
E 100 80 0 0
P 28
P 32
C 2 0
E 100 80 1 0
W 7
E 100 80 1 0
E 96 77 1 0
W 215
E 0 71 1 0
E 0 71 0 0
W 8
E 4 74 0 0
W 242
E 112 239 0 0
W 413
E 296 32 0 0
E 296 32 0 0
E 296 32 1 0
W 2
E 292 33 1 0
W 2
E 288 35 1 0
W 101
E 152 239 1 0
W 113
E 0 49 1 0
E 0 49 0 0
C 0 1
P 400
W 6
E 4 49 0 0
W 359
E 164 249 0 0
W 170
E 240 479 0 0
W 8
E 244 464 0 0
W 845
E 620 158 0 0
E 620 158 0 1
E 620 158 0 0
W 20
E 620 158 0 0

// File: build.f
source/geometry_pkg.sv
source/physics_pkg.sv
source/game_config_regs.sv
source/paddle_speed_estimator.sv
source/paddle_collision.sv
source/ball_motion.sv
source/game_top.sv
tests/tb_game_top.sv

// File: tests/tb_game_top.sv
module tb_game_top;
    timeunit 1ns;
    timeprecision 1ps;

    import geometry_pkg::*;

    localparam int BASE_PERIOD = 8;
    localparam int MAX_RECORDS = 256;
    localparam int MAX_GAP     = 8;

    logic      clk_25MHZ = 1'b0;
    logic      reset;
    logic      cfg_we;
    logic [1:0] cfg_addr;
    coord_t    cfg_data;
    logic      paddle_strobe;
    coord_t    paddle_y;
    ball_pos_t ball;
    logic      moving_left;
    logic      game_over;

    // Golden records as a command letter and up to four operands.
    logic [7:0] rec_cmd [MAX_RECORDS];
    int         rec_arg [MAX_RECORDS][4];
    int         rec_count;
    int         wait_total;
    int         cycle_limit;
    int         cycle_count;
    int         error_count;
    int         seed;

    game_top #(
        .BASE_PERIOD (BASE_PERIOD)
    ) uut (
        .clk_25MHZ     (clk_25MHZ),
        .reset         (reset),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .paddle_strobe (paddle_strobe),
        .paddle_y      (paddle_y),
        .ball          (ball),
        .moving_left   (moving_left),
        .game_over     (game_over)
    );

    initial begin
        forever #20 clk_25MHZ = ~clk_25MHZ;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at time %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    always @(posedge clk_25MHZ) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the golden file was not finished",
                                cycle_count));
        end
    end

    task automatic load_golden();
        int         fd;
        int         code;
        int         want;
        int         a0;
        int         a1;
        int         a2;
        int         a3;
        logic [7:0] cmd;
        logic [8*160-1:0] rest;
        bit         done;
        fd = $fopen("tests/game_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tests/game_golden.txt");
        end
        rec_count  = 0;
        wait_total = 0;
        done       = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else begin
                case (cmd)
                    "W", "P": begin
                        want = 1;
                        code = $fscanf(fd, "%d", a0);
                    end
                    "C": begin
                        want = 2;
                        code = $fscanf(fd, "%d %d", a0, a1);
                    end
                    "E": begin
                        want = 4;
                        code = $fscanf(fd, "%d %d %d %d", a0, a1, a2, a3);
                    end
                    default: begin
                        abort_run($sformatf("Unknown record type %c in the golden file", cmd));
                    end
                endcase
                if (code != want || rec_count >= MAX_RECORDS) begin
                    abort_run($sformatf("Golden record %0d is malformed", rec_count));
                end
                rec_cmd[rec_count]    = cmd;
                rec_arg[rec_count][0] = a0;
                rec_arg[rec_count][1] = a1;
                rec_arg[rec_count][2] = a2;
                rec_arg[rec_count][3] = a3;
                if (cmd == "W") begin
                    wait_total += a0;
                end
                rec_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic write_config(input logic [1:0] addr, input coord_t data);
        cfg_we   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(negedge clk_25MHZ);
        cfg_we   = 1'b0;
    endtask

    task automatic sample_paddle(input coord_t y);
        paddle_strobe = 1'b1;
        paddle_y      = y;
        @(negedge clk_25MHZ);
        paddle_strobe = 1'b0;
    endtask

    // Outputs are read just after the rising edge of the record's cycle.
    task automatic expect_outputs(input int x, input int y, input int left, input int over);
        @(posedge clk_25MHZ);
        #1;
        check_value("ball.x", ball.x, x);
        check_value("ball.y", ball.y, y);
        check_value("moving_left", moving_left, left);
        check_value("game_over", game_over, over);
        @(negedge clk_25MHZ);
    endtask

    initial begin
        int idx;
        int gap;
        reset         = 1'b1;
        cfg_we        = 1'b0;
        cfg_addr      = '0;
        cfg_data      = '0;
        paddle_strobe = 1'b0;
        paddle_y      = '0;
        seed          = 76;
        error_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 1000;
        load_golden();
        cycle_limit = 2 * wait_total + 200;
        repeat (3) @(negedge clk_25MHZ);
        reset = 1'b0;
        for (idx = 0; idx < rec_count; idx++) begin
            case (rec_cmd[idx])
                "W": begin
                    repeat (rec_arg[idx][0]) @(negedge clk_25MHZ);
                end
                "C": begin
                    // The ball sits idle before a start, so an extra gap changes nothing.
                    if (rec_arg[idx][0] == 2) begin
                        gap = $unsigned($random(seed)) % MAX_GAP;
                        repeat (gap) @(negedge clk_25MHZ);
                    end
                    write_config(rec_arg[idx][0][1:0], coord_t'(rec_arg[idx][1]));
                end
                "P": begin
                    sample_paddle(coord_t'(rec_arg[idx][0]));
                end
                default: begin
                    expect_outputs(rec_arg[idx][0], rec_arg[idx][1],
                                   rec_arg[idx][2], rec_arg[idx][3]);
                end
            endcase
        end
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: source/game_top.sv
module game_top #(
    parameter int unsigned BASE_PERIOD = 270000
) (
    input  logic                    clk_25MHZ,
    input  logic                    reset,
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_addr,
    input  geometry_pkg::coord_t    cfg_data,
    input  logic                    paddle_strobe,
    input  geometry_pkg::coord_t    paddle_y,
    output geometry_pkg::ball_pos_t ball,
    output logic                    moving_left,
    output logic                    game_over
);
    import geometry_pkg::*;
    import physics_pkg::*;

    game_config_t cfg;
    logic         start;
    coord_t       paddle_pos;
    speed_t       speed;
    logic         hit;
    logic         moving_right;

    game_config_regs u_config (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg       (cfg),
        .start     (start)
    );

    paddle_speed_estimator u_speed (
        .clk_25MHZ     (clk_25MHZ),
        .reset         (reset),
        .paddle_strobe (paddle_strobe),
        .paddle_y      (paddle_y),
        .paddle_pos    (paddle_pos),
        .speed         (speed)
    );

    paddle_collision u_collision (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .cfg          (cfg),
        .ball         (ball),
        .moving_right (moving_right),
        .paddle_pos   (paddle_pos),
        .hit          (hit)
    );

    ball_motion #(
        .BASE_PERIOD (BASE_PERIOD)
    ) u_motion (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .cfg          (cfg),
        .start        (start),
        .hit          (hit),
        .speed        (speed),
        .ball         (ball),
        .moving_left  (moving_left),
        .moving_right (moving_right),
        .game_over    (game_over)
    );

endmodule

// File: source/ball_motion.sv
module ball_motion #(
    parameter int unsigned BASE_PERIOD = 270000
) (
    input  logic                       clk_25MHZ,
    input  logic                       reset,
    input  geometry_pkg::game_config_t cfg,
    input  logic                       start,
    input  logic                       hit,
    input  physics_pkg::speed_t        speed,
    output geometry_pkg::ball_pos_t    ball,
    output logic                       moving_left,
    output logic                       moving_right,
    output logic                       game_over
);
    import geometry_pkg::*;
    import physics_pkg::*;

    localparam int CNT_W  = $clog2(BASE_PERIOD + 1);
    localparam int GRAV_W = $clog2(GRAVITY_INTERVAL);

    typedef logic [CNT_W-1:0] count_t;

    motion_state_t      state, state_next;
    ball_pos_t          ball_next;
    velocity_t          vel, vel_next, vel_grav;
    count_t             step_cnt, step_cnt_next;
    count_t             period, period_next, hit_period;
    logic [GRAV_W-1:0]  grav_cnt, grav_cnt_next;
    logic               game_over_next;
    logic               advance;
    logic signed [11:0] y_sum, y_limit;
    speed_t             safe_speed;

    assign moving_left  = (state == RUNNING_LEFT);
    assign moving_right = (state == RUNNING_RIGHT);

    // Candidate values for a step and for a paddle return.
    always_comb begin
        safe_speed = (speed < MIN_SPEED) ? speed_t'(MIN_SPEED) : speed;
        hit_period = count_t'(BASE_PERIOD / safe_speed);
        vel_grav   = (grav_cnt == GRAV_W'(GRAVITY_INTERVAL - 1)) ? vel + velocity_t'(1) : vel;
        y_sum      = signed'({2'b00, ball.y}) + vel;
        y_limit    = signed'({2'b00, field_y_max(cfg.upscale)});
    end

    always_comb begin
        state_next     = state;
        ball_next      = ball;
        vel_next       = vel;
        step_cnt_next  = step_cnt;
        grav_cnt_next  = grav_cnt;
        period_next    = period;
        game_over_next = 1'b0;
        advance        = 1'b0;

        case (state)
            IDLE: begin
                if (start) begin
                    state_next    = RUNNING_LEFT;
                    step_cnt_next = '0;
                end
            end

            RUNNING_LEFT: begin
                // Far wall reached, head back toward the paddle at base speed.
                if (ball.x == '0) begin
                    state_next    = RUNNING_RIGHT;
                    step_cnt_next = '0;
                    period_next   = count_t'(BASE_PERIOD);
                end else begin
                    advance = 1'b1;
                end
            end

            RUNNING_RIGHT: begin
                if (hit) begin
                    state_next    = RUNNING_LEFT;
                    step_cnt_next = '0;
                    period_next   = hit_period;
                end else if (ball.x >= field_miss_line(cfg.upscale)) begin
                    state_next     = IDLE;
                    game_over_next = 1'b1;
                end else begin
                    advance = 1'b1;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase

        if (advance) begin
            if (step_cnt >= period) begin
                step_cnt_next = '0;
                if (moving_left) begin
                    ball_next.x = ball.x - coord_t'(BALL_STEP);
                end else begin
                    ball_next.x = ball.x + coord_t'(BALL_STEP);
                end

                if (grav_cnt == GRAV_W'(GRAVITY_INTERVAL - 1)) begin
                    grav_cnt_next = '0;
                end else begin
                    grav_cnt_next = grav_cnt + 1'b1;
                end

                // Wall bounce flips the already updated velocity.
                vel_next = vel_grav;
                if (y_sum >= y_limit) begin
                    ball_next.y = coord_t'(y_limit);
                    vel_next    = -vel_grav;
                end else if (y_sum <= 12'sd0) begin
                    ball_next.y = '0;
                    vel_next    = -vel_grav;
                end else begin
                    ball_next.y = coord_t'(y_sum);
                end
            end else begin
                step_cnt_next = step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            ball      <= '{x: START_X, y: START_Y};
            vel       <= START_VEL;
            step_cnt  <= '0;
            grav_cnt  <= '0;
            period    <= count_t'(BASE_PERIOD);
            game_over <= 1'b0;
        end else begin
            state     <= state_next;
            ball      <= ball_next;
            vel       <= vel_next;
            step_cnt  <= step_cnt_next;
            grav_cnt  <= grav_cnt_next;
            period    <= period_next;
            game_over <= game_over_next;
        end
    end

    ball_inside_floor: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        ball.y <= field_y_max(cfg.upscale)
    ) else $error("ball below the bottom wall");

    ball_inside_right: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        {1'b0, ball.x} <= {1'b0, field_miss_line(cfg.upscale)} + 11'(BALL_STEP)
    ) else $error("ball past the miss line by more than one step");

endmodule

// File: source/paddle_collision.sv
module paddle_collision (
    input  logic                       clk_25MHZ,
    input  logic                       reset,
    input  geometry_pkg::game_config_t cfg,
    input  geometry_pkg::ball_pos_t    ball,
    input  logic                       moving_right,
    input  geometry_pkg::coord_t       paddle_pos,
    output logic                       hit
);
    import geometry_pkg::*;

    coord_t      paddle_line;
    logic [10:0] paddle_bottom;
    logic        in_box;
    logic        in_box_q;

    always_comb begin
        paddle_line   = field_paddle_line(cfg.upscale);
        // One extra bit so a paddle near the bottom does not wrap.
        paddle_bottom = {1'b0, paddle_pos} + {1'b0, cfg.paddle_height};
        in_box = moving_right
              && (ball.x >= paddle_line)
              && (ball.y >= paddle_pos)
              && ({1'b0, ball.y} < paddle_bottom);
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            in_box_q <= 1'b0;
            hit      <= 1'b0;
        end else begin
            in_box_q <= in_box;
            hit      <= in_box && !in_box_q;
        end
    end

endmodule

// File: source/paddle_speed_estimator.sv
module paddle_speed_estimator (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 paddle_strobe,
    input  geometry_pkg::coord_t paddle_y,
    output geometry_pkg::coord_t paddle_pos,
    output physics_pkg::speed_t  speed
);
    import physics_pkg::*;

    logic   sample_valid;
    speed_t delta;

    // Distance moved since the previous sample.
    always_comb begin
        if (paddle_y >= paddle_pos) begin
            delta = paddle_y - paddle_pos;
        end else begin
            delta = paddle_pos - paddle_y;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            paddle_pos   <= '0;
            sample_valid <= 1'b0;
            speed        <= '0;
        end else if (paddle_strobe) begin
            paddle_pos   <= paddle_y;
            sample_valid <= 1'b1;
            // No previous sample yet, so keep the speed.
            if (sample_valid) begin
                speed <= delta;
            end
        end
    end

endmodule

// File: source/game_config_regs.sv
module game_config_regs (
    input  logic                       clk_25MHZ,
    input  logic                       reset,
    input  logic                       cfg_we,
    input  logic [1:0]                 cfg_addr,
    input  geometry_pkg::coord_t       cfg_data,
    output geometry_pkg::game_config_t cfg,
    output logic                       start
);
    import geometry_pkg::*;

    localparam logic [1:0] ADDR_MODE   = 2'd0;
    localparam logic [1:0] ADDR_HEIGHT = 2'd1;
    localparam logic [1:0] ADDR_START  = 2'd2;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            cfg.upscale       <= 1'b0;
            cfg.paddle_height <= coord_t'(DEFAULT_PADDLE_HEIGHT);
            start             <= 1'b0;
        end else begin
            // Start is a command only and leaves the stored fields alone.
            start <= cfg_we && (cfg_addr == ADDR_START);
            if (cfg_we) begin
                case (cfg_addr)
                    ADDR_MODE: begin
                        cfg.upscale <= cfg_data[0];
                    end
                    ADDR_HEIGHT: begin
                        cfg.paddle_height <= cfg_data;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    start_single_pulse: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        start |=> !start
    ) else $error("start command held for two cycles");

endmodule

// File: source/physics_pkg.sv
package physics_pkg;

    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        RUNNING_LEFT  = 2'd1,
        RUNNING_RIGHT = 2'd2
    } motion_state_t;

    // Positive velocity moves the ball down the screen.
    typedef logic signed [9:0] velocity_t;

    typedef logic [9:0] speed_t;

    localparam int unsigned BALL_STEP        = 4;
    localparam int unsigned GRAVITY_INTERVAL = 4;
    localparam int unsigned MIN_SPEED        = 1;

    localparam geometry_pkg::coord_t START_X   = 10'd100;
    localparam geometry_pkg::coord_t START_Y   = 10'd80;
    localparam velocity_t            START_VEL = -10'sd3;

endpackage

// File: source/geometry_pkg.sv
package geometry_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } ball_pos_t;

    typedef struct packed {
        logic   upscale;
        coord_t paddle_height;
    } game_config_t;

    localparam int unsigned WIDTH_NORMAL          = 320;
    localparam int unsigned WIDTH_UPSCALED        = 640;
    localparam int unsigned HEIGHT_NORMAL         = 240;
    localparam int unsigned HEIGHT_UPSCALED       = 480;
    localparam int unsigned EDGE_MARGIN           = 20;
    localparam int unsigned PADDLE_DEPTH          = 4;
    localparam int unsigned DEFAULT_PADDLE_HEIGHT = 40;

    function automatic coord_t field_y_max(input logic upscale);
        return upscale ? coord_t'(HEIGHT_UPSCALED - 1) : coord_t'(HEIGHT_NORMAL - 1);
    endfunction

    // Ball is lost once it reaches this column.
    function automatic coord_t field_miss_line(input logic upscale);
        return upscale ? coord_t'(WIDTH_UPSCALED - EDGE_MARGIN)
                       : coord_t'(WIDTH_NORMAL - EDGE_MARGIN);
    endfunction

    function automatic coord_t field_paddle_line(input logic upscale);
        return field_miss_line(upscale) - coord_t'(PADDLE_DEPTH);
    endfunction

endpackage
